//--- src.f
rom_map_pkg.sv
sdram_bus_pkg.sv
rom_slot.sv
slot_arbiter.sv
sdram_return.sv
rom_bank.sv
sdram_model.sv
tb_rom_bank.sv

//--- run.sh
#!/bin/bash
# Build and run the rom_bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module tb_rom_bank \
    -f src.f -o tb_rom_bank > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_rom_bank > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

//--- tb_rom_bank.sv
// Checks read data, SDRAM handshake, grant order and cache reuse. Runs 200 accesses per slot
module tb_rom_bank
    import rom_map_pkg::*, sdram_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCESSES = 200;
    localparam int TIMEOUT  = NUM_SLOTS * ACCESSES * 16;

    logic                 clk;
    logic                 reset;
    logic                 downloading;
    logic [NUM_SLOTS-1:0] slot_cs;
    logic [SLOT_AW-1:0]   slot_addr [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] slot_ok;
    logic [SLOT_DW-1:0]   slot_dout [NUM_SLOTS];
    logic                 sdram_req;
    logic [SDRAM_AW-1:0]  sdram_addr;
    logic                 sdram_ack;
    logic                 data_rdy;
    logic [SDRAM_DW-1:0]  data_read;

    logic [15:0]          lfsr = 16'd21;
    int                   cycles;
    int                   acc_cnt [NUM_SLOTS];
    int                   phase [NUM_SLOTS];
    int                   grants [NUM_SLOTS];
    logic [WORD_AW-1:0]   prev_word [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] have_prev;
    logic [NUM_SLOTS-1:0] reuse;
    logic [NUM_SLOTS-1:0] dl_since;
    logic [NUM_SLOTS-1:0] pend_q;
    logic                 reset_q;
    logic                 req_q;
    logic                 ack_q;
    logic                 dl_q;
    logic                 outstanding;
    logic                 dl_started;
    logic [SDRAM_AW-1:0]  addr_q;
    slot_id_t             last_grant;
    int                   dl_timer;

    rom_bank uut (.*);

    sdram_model u_sdram (.*);

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Model word at even A is {~A, A}, so an odd halfword reads the inverse of its even neighbour
    function automatic logic [15:0] expected_half(input int slot, input logic [15:0] a);
        logic [21:0] h;
        h = SLOT_OFFSET[slot] + 22'(a);
        return h[0] ? ~{h[15:1], 1'b0} : h[15:0];
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic fail_run(input string what);
        $display("%0t %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset       <= 1'b1;
        downloading <= 1'b0;
        slot_cs     <= '0;
        for (int i = 0; i < NUM_SLOTS; i++) slot_addr[i] <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

    always @(posedge clk) begin
        logic [15:0] a;
        slot_id_t    o;
        int          idx;
        logic        passed;
        logic        all_done;
        if (reset_q) begin  // First sample after a reset edge
            assert (!sdram_req) else value_error("sdram_req", 0, sdram_req);
            assert (slot_ok == '0) else value_error("slot_ok", 0, slot_ok);
        end
        if (downloading && dl_q) assert (slot_ok == '0) else value_error("slot_ok", 0, slot_ok);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slot_ok[i]) assert (slot_dout[i] == expected_half(i, slot_addr[i]))
                else value_error($sformatf("slot_dout[%0d]", i),
                                 expected_half(i, slot_addr[i]), slot_dout[i]);
        end
        if (req_q && !ack_q) begin  // Request must hold until ack
            assert (sdram_req) else fail_run("sdram_req dropped before sdram_ack");
            assert (sdram_addr == addr_q) else value_error("sdram_addr", addr_q, sdram_addr);
        end
        if (sdram_req && !req_q) begin  // New grant
            o = uut.owner;
            assert (!outstanding) else fail_run("new sdram_req before data_rdy of the last one");
            assert (!dl_q) else fail_run("grant made while downloading");
            assert (pend_q[o]) else fail_run("grant to a slot with no pending miss");
            passed = 1'b0;
            for (int s = 1; s < NUM_SLOTS; s++) begin
                idx = (int'(last_grant) + s) % NUM_SLOTS;
                if (idx == int'(o)) passed = 1'b1;
                if (!passed) assert (!pend_q[idx])
                    else fail_run($sformatf("round-robin skipped waiting slot %0d", idx));
            end
            grants[o]++;
            last_grant = o;
        end
        if (sdram_ack) outstanding = 1'b1;
        if (data_rdy) outstanding = 1'b0;
        if (downloading) dl_since = '1;

        // Client stimulus
        if (!reset) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                case (phase[i])
                    0: if (acc_cnt[i] < ACCESSES) begin
                        a = rand_bits(16);
                        if (rand_bits(1) == 16'd1 && have_prev[i]) begin
                            a = {prev_word[i], a[0]};  // Same word as last time
                            reuse[i] = !dl_since[i];
                        end else begin
                            reuse[i] = 1'b0;
                        end
                        grants[i]    = 0;
                        slot_cs[i]   <= 1'b1;
                        slot_addr[i] <= a;
                        phase[i]     = 1;
                    end
                    1: if (slot_ok[i]) begin
                        if (reuse[i] && !dl_since[i]) assert (grants[i] == 0)
                            else fail_run($sformatf("slot %0d refetched a cached word", i));
                        prev_word[i] = slot_addr[i][SLOT_AW-1:1];
                        have_prev[i] = 1'b1;
                        dl_since[i]  = downloading;
                        acc_cnt[i]++;
                        slot_cs[i]   <= 1'b0;
                        phase[i]     = 2;
                    end
                    default: phase[i] = 0;  // One idle cycle lets the stale ok pass
                endcase
            end
            if (acc_cnt[0] == ACCESSES / 2 && !dl_started) begin
                dl_started = 1'b1;
                downloading <= 1'b1;
                dl_timer = 20;
            end else if (dl_timer > 0) begin
                dl_timer--;
                if (dl_timer == 0) downloading <= 1'b0;
            end
        end

        for (int k = 0; k < NUM_SLOTS; k++) pend_q[k] = uut.reqs[k].pending;
        reset_q = reset;
        req_q   = sdram_req;
        ack_q   = sdram_ack;
        addr_q  = sdram_addr;
        dl_q    = downloading;
        cycles++;

        all_done = 1'b1;
        for (int i = 0; i < NUM_SLOTS; i++) if (acc_cnt[i] < ACCESSES) all_done = 1'b0;
        if (all_done) begin
            $display("TEST PASS");
            $finish;
        end else if (cycles >= TIMEOUT) begin
            fail_run("timeout, accesses did not complete");
        end
    end

    initial begin
        cycles      = 0;
        have_prev   = '0;
        reuse       = '0;
        dl_since    = '0;
        pend_q      = '0;
        reset_q     = 1'b0;
        req_q       = 1'b0;
        ack_q       = 1'b0;
        dl_q        = 1'b0;
        outstanding = 1'b0;
        dl_started  = 1'b0;
        dl_timer    = 0;
        last_grant  = slot_id_t'(NUM_SLOTS - 1);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            acc_cnt[i] = 0;
            phase[i]   = 0;
            grants[i]  = 0;
        end
    end

endmodule

//--- sdram_model.sv
// Testbench SDRAM read port. One transaction at a time, data derived from the halfword address
module sdram_model
    import sdram_bus_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                sdram_req,
    input  logic [SDRAM_AW-1:0] sdram_addr,
    output logic                sdram_ack,
    output logic                data_rdy,
    output logic [SDRAM_DW-1:0] data_read
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0]         lfsr = 16'd21;
    logic [1:0]          state;
    int                  cnt;
    logic [SDRAM_AW-1:0] addr_q;

    // Galois LFSR stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            state     <= 2'd0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
        end else begin
            case (state)
                2'd0: if (sdram_req) begin
                    cnt   <= 1 + int'(rand_bits(2));  // Ack delay 1 to 4
                    state <= 2'd1;
                end
                2'd1: if (cnt == 1) begin
                    sdram_ack <= 1'b1;
                    addr_q    <= sdram_addr;
                    cnt       <= int'(rand_bits(3)) % 6 + 1;  // Data delay 1 to 6
                    state     <= 2'd2;
                end else begin
                    cnt <= cnt - 1;
                end
                2'd2: begin
                    sdram_ack <= 1'b0;
                    if (cnt == 1) begin
                        data_rdy  <= 1'b1;
                        data_read <= {~addr_q[15:0], addr_q[15:0]};
                        state     <= 2'd3;
                    end else begin
                        cnt <= cnt - 1;
                    end
                end
                default: begin
                    data_rdy <= 1'b0;
                    state    <= 2'd0;
                end
            endcase
        end
    end

endmodule

//--- rom_bank.sv
// Four 16-bit slots sharing one SDRAM read port. No refresh control and no download write path
module rom_bank
    import rom_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 downloading,
    // Client slots
    input  logic [NUM_SLOTS-1:0] slot_cs,
    input  logic [SLOT_AW-1:0]   slot_addr [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0] slot_ok,
    output logic [SLOT_DW-1:0]   slot_dout [NUM_SLOTS],
    // SDRAM read port
    output logic                 sdram_req,
    output logic [SDRAM_AW-1:0]  sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  logic [SDRAM_DW-1:0]  data_read
);

    slot_req_t  reqs [NUM_SLOTS];
    slot_fill_t fill;
    slot_id_t   owner;

    sdram_return u_return (
        .clk         ( clk           ),
        .reset       ( reset         ),
        .data_rdy    ( data_rdy      ),
        .data_read   ( data_read     ),
        .owner       ( owner         ),
        .fill        ( fill          )
    );

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        rom_slot u_slot (
            .clk         ( clk              ),
            .reset       ( reset            ),
            .downloading ( downloading      ),
            .cs          ( slot_cs[i]       ),
            .addr        ( slot_addr[i]     ),
            .slot_idx    ( slot_id_t'(i)    ),
            .fill        ( fill             ),
            .req         ( reqs[i]          ),
            .ok          ( slot_ok[i]       ),
            .dout        ( slot_dout[i]     )
        );
    end

    slot_arbiter u_arbiter (
        .clk         ( clk           ),
        .reset       ( reset         ),
        .downloading ( downloading   ),
        .reqs        ( reqs          ),
        .sdram_ack   ( sdram_ack     ),
        .data_rdy    ( data_rdy      ),
        .sdram_req   ( sdram_req     ),
        .sdram_addr  ( sdram_addr    ),
        .owner       ( owner         )
    );

endmodule

//--- sdram_return.sv
// Owner must stay stable from ack until data_rdy, which the arbiter guarantees
module sdram_return
    import rom_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                data_rdy,
    input  logic [SDRAM_DW-1:0] data_read,
    input  slot_id_t            owner,
    output slot_fill_t          fill
);

    // One-cycle fill pulse seen by all slots
    always_ff @(posedge clk) begin
        if (reset) begin
            fill.valid <= 1'b0;
        end else begin
            fill.valid <= data_rdy;
        end
        if (data_rdy) begin
            fill.slot <= owner;      // Tags the word for its slot
            fill.data <= data_read;
        end
    end

endmodule

//--- slot_arbiter.sv
// One SDRAM read at a time. A new grant waits for data_rdy and the fill cycle after it
module slot_arbiter
    import rom_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                downloading,
    input  slot_req_t           reqs [NUM_SLOTS],
    input  logic                sdram_ack,
    input  logic                data_rdy,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output slot_id_t            owner
);

    typedef enum logic [1:0] {IDLE, REQ, BUSY, DRAIN} state_t;

    state_t   state;
    slot_id_t pick;
    logic     found;

    // Owner doubles as the pointer so the search starts just after the last slot served
    always_comb begin
        slot_id_t cand;
        pick  = owner;
        found = 1'b0;
        for (int k = NUM_SLOTS; k >= 1; k--) begin
            cand = slot_id_t'(int'(owner) + k);  // Wraps on the index width
            if (reqs[cand].pending) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            owner     <= slot_id_t'(NUM_SLOTS - 1);  // Slot 0 goes first
        end else begin
            case (state)
                IDLE: if (found && !downloading) begin
                    owner     <= pick;
                    sdram_req <= 1'b1;
                    state     <= REQ;
                end
                REQ: if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= BUSY;
                end
                BUSY: if (data_rdy) state <= DRAIN;
                // Owner still shows pending while its fill is in flight
                DRAIN: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Frozen outside IDLE so the address holds until ack
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            sdram_addr <= SLOT_OFFSET[pick] + SDRAM_AW'({reqs[pick].word_addr, 1'b0});
        end
    end

endmodule

//--- rom_slot.sv
// Client must hold cs and addr until ok. A stale ok can follow for one cycle if addr moves early
module rom_slot
    import rom_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               downloading,
    input  logic               cs,
    input  logic [SLOT_AW-1:0] addr,
    input  slot_id_t           slot_idx,
    input  slot_fill_t         fill,
    output slot_req_t          req,
    output logic               ok,
    output logic [SLOT_DW-1:0] dout
);

    logic [WORD_AW-1:0]  tag;       // Word address of the cached word or of the pending miss
    logic                valid;
    logic                pending;
    logic [SDRAM_DW-1:0] word;
    logic [SDRAM_DW-1:0] src;       // Word the halfword is taken from
    logic                hit;
    logic                own_fill;
    logic                miss;

    assign hit      = cs && valid && (tag == addr[SLOT_AW-1:1]);
    assign own_fill = fill.valid && (fill.slot == slot_idx) && pending;
    assign miss     = cs && !hit && !pending;

    // Returned word is forwarded straight to dout
    assign src = own_fill ? fill.data : word;

    assign req.pending   = pending;
    assign req.word_addr = tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid   <= 1'b0;
            pending <= 1'b0;
            ok      <= 1'b0;
        end else if (downloading) begin
            // ROM contents are changing so everything cached is dropped
            valid   <= 1'b0;
            pending <= pending && !own_fill;  // In-flight read is discarded
            ok      <= 1'b0;
        end else begin
            ok <= hit || (own_fill && cs);
            if (own_fill) begin
                valid   <= 1'b1;
                pending <= 1'b0;
            end else if (miss) begin
                valid   <= 1'b0;  // Tag now names the word being fetched
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            tag <= addr[SLOT_AW-1:1];
        end
        if (own_fill) begin
            word <= fill.data;
        end
        if (hit || own_fill) begin
            // Even address reads the low half, odd the high half
            dout <= addr[0] ? src[2*SLOT_DW-1:SLOT_DW] : src[SLOT_DW-1:0];
        end
    end

endmodule

//--- sdram_bus_pkg.sv
// SDRAM side is 22-bit halfword addressed with 32-bit reads and a single outstanding transaction
package sdram_bus_pkg;

    import rom_map_pkg::*;

    localparam int SDRAM_AW = 22;            // Halfword address
    localparam int SDRAM_DW = 32;            // One read returns two halfwords
    localparam int WORD_AW  = SLOT_AW - 1;   // Client address without the halfword bit

    // Miss request from one slot to the arbiter
    typedef struct packed {
        logic               pending;     // High from the miss until the fill lands
        logic [WORD_AW-1:0] word_addr;
    } slot_req_t;

    // Read word broadcast from the return stage to every slot
    typedef struct packed {
        logic                valid;      // One-cycle pulse
        slot_id_t            slot;       // Slot that asked for this word
        logic [SDRAM_DW-1:0] data;
    } slot_fill_t;

endpackage

//--- rom_map_pkg.sv
// Four fixed client slots with 16-bit halfword addresses and offsets counted in halfwords
package rom_map_pkg;

    // Slot count must stay a power of two because the round-robin pointer wraps on its width
    localparam int NUM_SLOTS = 4;

    localparam int SLOT_AW = 16;   // Client halfword address
    localparam int SLOT_DW = 16;   // Client read data
    localparam int OFFSET_W = 22;  // Spans the whole ROM image

    // Slot index
    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_id_t;

    // Start of each client region inside the downloaded ROM image.
    // Regions are laid out like the game's .rom file so the
    // download order needs no remapping.
    localparam logic [OFFSET_W-1:0] SLOT_OFFSET [NUM_SLOTS] = '{
        22'h0_0000,   // Main CPU code
        22'h2_0000,   // Sound CPU code
        22'h5_0000,   // Tile graphics
        22'h8_0000    // Object graphics
    };

endpackage
